/* rtl/bbc_consts.svh */
`ifndef BBC_CONSTS_SVH
`define BBC_CONSTS_SVH

// Memory cycle divider, 16 phases of the 32 MHz clock
`define BBC_PHASE_BITS 4
`define BBC_PHI0_START 4'd8

// SHEILA registers, compared against cpu address bits 15..2
`define BBC_ROMSEL_ADDR 14'h3F8C
`define BBC_ACCCON_ADDR 14'h3F8D

// Opcode fetches from C000-DFFF count as VDU driver code
`define BBC_VDU_REGION 3'b110

// Shadow window 3000-7FFF, on address bits 15..12
`define BBC_SHADOW_FIRST 4'h3
`define BBC_SHADOW_LAST 4'h7

// Screen wrap offsets added to MA bits 11..8
// Mode 3 restarts at 4000
`define BBC_WRAP_OFFS_0 4'd8
// Mode 6 restarts at 6000
`define BBC_WRAP_OFFS_1 4'd12
// Modes 0, 1 and 2 restart at 3000
`define BBC_WRAP_OFFS_2 4'd6
// Modes 4 and 5 restart at 5800
`define BBC_WRAP_OFFS_3 4'd11

`endif

/* rtl/bbc_bus_pkg.sv */
`include "bbc_consts.svh"

package bbc_bus_pkg;

	typedef logic [15:0] cpu_addr_t;
	typedef logic [7:0] cpu_data_t;

	// ROM select latch at FE30
	typedef logic [7:0] romsel_t;

	// Access control at FE34, IRR TST IFJ ITU Y X E D from bit 7 down
	typedef logic [7:0] acccon_t;

	// Position within one CPU memory cycle
	typedef logic [`BBC_PHASE_BITS-1:0] cpu_phase_t;

endpackage

/* rtl/bbc_video_pkg.sv */
package bbc_video_pkg;

	// CRTC refresh address
	typedef logic [13:0] crtc_ma_t;

	// CRTC raster row within a character
	typedef logic [4:0] crtc_ra_t;

	// Byte address into the 32K screen RAM
	typedef logic [14:0] disp_addr_t;

	// Selects one of four wrap offsets, set by the screen mode
	typedef logic [1:0] disp_offs_t;

endpackage

/* rtl/bbc_clocks.sv */
`include "bbc_consts.svh"

module bbc_clocks (
	input  logic CLK32M_I,
	input  logic reset_n,
	output logic cpu_clken_o,
	output logic phi0_o
);

	bbc_bus_pkg::cpu_phase_t phase;

	// Free running, one lap per memory cycle
	always_ff @(posedge CLK32M_I) begin
		if (!reset_n) begin
			phase <= '0;
		end else begin
			phase <= phase + 1'b1;
		end
	end

	// Second half of the cycle belongs to the CPU
	assign phi0_o = (phase >= `BBC_PHI0_START);

	// CPU advances at the end of its slot
	assign cpu_clken_o = &phase;

endmodule

/* rtl/bbc_sys_regs.sv */
`include "bbc_consts.svh"

module bbc_sys_regs (
	input  logic                    CLK32M_I,
	input  logic                    reset_n,
	input  logic                    cpu_clken_i,
	input  logic                    model_i,
	input  logic                    cpu_r_nw_i,
	input  logic                    cpu_sync_i,
	input  bbc_bus_pkg::cpu_addr_t  cpu_a_i,
	input  bbc_bus_pkg::cpu_data_t  cpu_do_i,
	output bbc_bus_pkg::romsel_t    romsel_o,
	output logic                    acc_y_o,
	output logic                    acc_d_o,
	output logic                    shadow_ram_o,
	output bbc_bus_pkg::cpu_data_t  cpu_di_o
);

	bbc_bus_pkg::romsel_t romsel;
	bbc_bus_pkg::acccon_t acccon;
	logic vdu_op;

	logic romsel_sel;
	logic acccon_sel;
	logic cpu_wr;
	logic in_shadow;

	// Register decode ignores the low two address bits
	assign romsel_sel = (cpu_a_i[15:2] == `BBC_ROMSEL_ADDR);
	assign acccon_sel = (cpu_a_i[15:2] == `BBC_ACCCON_ADDR);
	assign cpu_wr = cpu_clken_i & ~cpu_r_nw_i;

	always_ff @(posedge CLK32M_I) begin
		if (!reset_n) begin
			romsel <= '0;
		end else if (cpu_wr && romsel_sel) begin
			// Original model has only 16 ROM slots and no RAM bit
			romsel <= {cpu_do_i[7] & model_i, cpu_do_i[6:0]};
		end
	end

	// Only the Master has FE34
	always_ff @(posedge CLK32M_I) begin
		if (!reset_n) begin
			acccon <= '0;
		end else if (cpu_wr && acccon_sel && model_i) begin
			acccon <= cpu_do_i;
		end
	end

	// Remember where the last opcode came from
	always_ff @(posedge CLK32M_I) begin
		if (!reset_n) begin
			vdu_op <= 1'b0;
		end else if (cpu_clken_i && cpu_sync_i) begin
			vdu_op <= (cpu_a_i[15:13] == `BBC_VDU_REGION);
		end
	end

	assign in_shadow = (cpu_a_i[15:12] >= `BBC_SHADOW_FIRST) &&
		(cpu_a_i[15:12] <= `BBC_SHADOW_LAST);

	// X maps the window always; E only for VDU code data accesses
	assign shadow_ram_o = in_shadow &&
		(acccon[2] || (acccon[1] && vdu_op && !cpu_sync_i));

	always_comb begin
		cpu_di_o = '0;
		if (model_i) begin
			if (acccon_sel) begin
				cpu_di_o = acccon;
			end else if (romsel_sel) begin
				cpu_di_o = romsel;
			end
		end
	end

	assign romsel_o = romsel;
	assign acc_y_o = acccon[3];
	assign acc_d_o = acccon[0];

endmodule

/* rtl/bbc_ic32_latch.sv */
module bbc_ic32_latch (
	input  logic                      CLK32M_I,
	input  logic                      reset_n,
	input  bbc_bus_pkg::cpu_data_t    sys_pb_i,
	output bbc_video_pkg::disp_offs_t disp_offs_o,
	output logic                      sound_enable_n_o,
	output logic                      keyb_enable_n_o,
	output logic                      caps_lock_led_n_o,
	output logic                      shift_lock_led_n_o
);

	logic [7:0] ic32;

	// PB2..0 address one latch bit, PB3 is its new value
	always_ff @(posedge CLK32M_I) begin
		if (!reset_n) begin
			ic32 <= '0;
		end else begin
			ic32[sys_pb_i[2:0]] <= sys_pb_i[3];
		end
	end

	// Bits 1 and 2 went to the speech chip, unused here
	assign sound_enable_n_o = ic32[0];
	assign keyb_enable_n_o = ic32[3];
	assign disp_offs_o = ic32[5:4];
	assign caps_lock_led_n_o = ic32[6];
	assign shift_lock_led_n_o = ic32[7];

endmodule

/* rtl/bbc_display_addr.sv */
`include "bbc_consts.svh"

module bbc_display_addr (
	input  bbc_video_pkg::crtc_ma_t   crtc_ma_i,
	input  bbc_video_pkg::crtc_ra_t   crtc_ra_i,
	input  bbc_video_pkg::disp_offs_t disp_offs_i,
	output bbc_video_pkg::disp_addr_t disp_a_o
);

	logic [3:0] wrap_offs;
	logic [3:0] nibble;

	always_comb begin
		case (disp_offs_i)
			2'b00: wrap_offs = `BBC_WRAP_OFFS_0;
			2'b01: wrap_offs = `BBC_WRAP_OFFS_1;
			2'b10: wrap_offs = `BBC_WRAP_OFFS_2;
			default: wrap_offs = `BBC_WRAP_OFFS_3;
		endcase
	end

	// MA12 marks an address past 8000 that must wrap back into the screen
	assign nibble = crtc_ma_i[11:8] + (crtc_ma_i[12] ? wrap_offs : 4'd0);

	always_comb begin
		if (crtc_ma_i[13]) begin
			// Teletext, 1K screen at 3C00 or 7C00
			disp_a_o = {nibble[3], 4'b1111, crtc_ma_i[9:0]};
		end else begin
			// Bitmap modes, 8 raster rows per character cell
			disp_a_o = {nibble, crtc_ma_i[7:0], crtc_ra_i[2:0]};
		end
	end

endmodule

/* rtl/bbc_glue.sv */
module bbc_glue (
	input  logic                     CLK32M_I,
	input  logic                     reset_n,
	input  logic                     model_i,
	input  logic                     cpu_r_nw_i,
	input  logic                     cpu_sync_i,
	input  bbc_bus_pkg::cpu_addr_t   cpu_a_i,
	input  bbc_bus_pkg::cpu_data_t   cpu_do_i,
	input  bbc_video_pkg::crtc_ma_t  crtc_ma_i,
	input  bbc_video_pkg::crtc_ra_t  crtc_ra_i,
	input  bbc_bus_pkg::cpu_data_t   sys_pb_i,
	output bbc_bus_pkg::cpu_addr_t   mem_adr_o,
	output logic                     mem_we_o,
	output bbc_bus_pkg::cpu_data_t   mem_do_o,
	output bbc_bus_pkg::cpu_data_t   cpu_di_o,
	output logic                     phi0_o,
	output logic                     mem_sync_o,
	output bbc_bus_pkg::romsel_t     romsel_o,
	output logic                     acc_y_o,
	output logic                     shadow_ram_o,
	output logic                     shadow_vid_o,
	output logic                     sound_enable_n_o,
	output logic                     keyb_enable_n_o,
	output logic                     caps_lock_led_n_o,
	output logic                     shift_lock_led_n_o
);

	logic cpu_clken;
	logic phi0;
	logic acc_d;
	bbc_video_pkg::disp_offs_t disp_offs;
	bbc_video_pkg::disp_addr_t disp_a;

	bbc_clocks u_clocks (
		.CLK32M_I    (CLK32M_I),
		.reset_n     (reset_n),
		.cpu_clken_o (cpu_clken),
		.phi0_o      (phi0)
	);

	bbc_sys_regs u_sys_regs (
		.CLK32M_I     (CLK32M_I),
		.reset_n      (reset_n),
		.cpu_clken_i  (cpu_clken),
		.model_i      (model_i),
		.cpu_r_nw_i   (cpu_r_nw_i),
		.cpu_sync_i   (cpu_sync_i),
		.cpu_a_i      (cpu_a_i),
		.cpu_do_i     (cpu_do_i),
		.romsel_o     (romsel_o),
		.acc_y_o      (acc_y_o),
		.acc_d_o      (acc_d),
		.shadow_ram_o (shadow_ram_o),
		.cpu_di_o     (cpu_di_o)
	);

	bbc_ic32_latch u_ic32 (
		.CLK32M_I           (CLK32M_I),
		.reset_n            (reset_n),
		.sys_pb_i           (sys_pb_i),
		.disp_offs_o        (disp_offs),
		.sound_enable_n_o   (sound_enable_n_o),
		.keyb_enable_n_o    (keyb_enable_n_o),
		.caps_lock_led_n_o  (caps_lock_led_n_o),
		.shift_lock_led_n_o (shift_lock_led_n_o)
	);

	bbc_display_addr u_disp_addr (
		.crtc_ma_i   (crtc_ma_i),
		.crtc_ra_i   (crtc_ra_i),
		.disp_offs_i (disp_offs),
		.disp_a_o    (disp_a)
	);

	// Video owns the RAM in the first half of each cycle
	assign mem_adr_o = phi0 ? cpu_a_i : {1'b0, disp_a};
	assign mem_we_o = ~cpu_r_nw_i & phi0;
	assign mem_do_o = cpu_do_i;

	// SDRAM controller locks onto the CPU cycle
	assign mem_sync_o = cpu_clken;
	assign phi0_o = phi0;
	assign shadow_vid_o = acc_d;

endmodule

/* tests/tb_clock_gen.sv */
module tb_clock_gen #(
	parameter int PERIOD = 40,
	parameter int RESET_CYCLES = 5
) (
	output logic clk_o,
	output logic reset_n_o
);

	initial begin
		clk_o = 1'b0;
		forever #(PERIOD / 2) clk_o = ~clk_o;
	end

	// Release on a falling edge, away from the sampling edge
	initial begin
		reset_n_o = 1'b0;
		repeat (RESET_CYCLES) @(posedge clk_o);
		@(negedge clk_o);
		reset_n_o = 1'b1;
	end

endmodule

/* tests/tb_bbc_glue.sv */
module tb_bbc_glue;

	localparam logic [15:0] ROMSEL_ADDR = 16'hFE30;
	localparam logic [15:0] ACCCON_ADDR = 16'hFE34;
	// All tests together take about 1250 cycles
	localparam int MAX_CYCLES = 4000;

	logic clk32m;
	logic reset_n;

	logic model;
	logic cpu_r_nw;
	logic cpu_sync;
	bbc_bus_pkg::cpu_addr_t cpu_a;
	bbc_bus_pkg::cpu_data_t cpu_do;
	bbc_video_pkg::crtc_ma_t crtc_ma;
	bbc_video_pkg::crtc_ra_t crtc_ra;
	bbc_bus_pkg::cpu_data_t sys_pb;

	bbc_bus_pkg::cpu_addr_t mem_adr;
	logic mem_we;
	bbc_bus_pkg::cpu_data_t mem_do;
	bbc_bus_pkg::cpu_data_t cpu_di;
	logic phi0;
	logic mem_sync;
	bbc_bus_pkg::romsel_t romsel;
	logic acc_y;
	logic shadow_ram;
	logic shadow_vid;
	logic sound_enable_n;
	logic keyb_enable_n;
	logic caps_lock_led_n;
	logic shift_lock_led_n;

	// Reference model state advanced by the checker
	logic [3:0] ref_phase;
	bbc_bus_pkg::romsel_t ref_romsel;
	bbc_bus_pkg::acccon_t ref_acccon;
	logic ref_vdu_op;
	logic [7:0] ref_ic32;
	bbc_bus_pkg::cpu_addr_t exp_adr;
	int phi0_run;

	int seed = 52009;
	logic [31:0] rnd;
	int errors = 0;
	int n_checks = 0;
	int cycle_count = 0;
	int test_start;

	tb_clock_gen #(.PERIOD(40), .RESET_CYCLES(5)) u_clock_gen (
		.clk_o     (clk32m),
		.reset_n_o (reset_n)
	);

	bbc_glue UUT (
		.CLK32M_I           (clk32m),
		.reset_n            (reset_n),
		.model_i            (model),
		.cpu_r_nw_i         (cpu_r_nw),
		.cpu_sync_i         (cpu_sync),
		.cpu_a_i            (cpu_a),
		.cpu_do_i           (cpu_do),
		.crtc_ma_i          (crtc_ma),
		.crtc_ra_i          (crtc_ra),
		.sys_pb_i           (sys_pb),
		.mem_adr_o          (mem_adr),
		.mem_we_o           (mem_we),
		.mem_do_o           (mem_do),
		.cpu_di_o           (cpu_di),
		.phi0_o             (phi0),
		.mem_sync_o         (mem_sync),
		.romsel_o           (romsel),
		.acc_y_o            (acc_y),
		.shadow_ram_o       (shadow_ram),
		.shadow_vid_o       (shadow_vid),
		.sound_enable_n_o   (sound_enable_n),
		.keyb_enable_n_o    (keyb_enable_n),
		.caps_lock_led_n_o  (caps_lock_led_n),
		.shift_lock_led_n_o (shift_lock_led_n)
	);

	// Screen RAM address for a CRTC address with the mode wrap applied
	function automatic bbc_video_pkg::disp_addr_t disp_addr_ref(
		input bbc_video_pkg::crtc_ma_t ma,
		input bbc_video_pkg::crtc_ra_t ra,
		input bbc_video_pkg::disp_offs_t offs
	);
		logic [3:0] add;
		logic [3:0] nib;
		case (offs)
			2'd0: add = 4'd8;
			2'd1: add = 4'd12;
			2'd2: add = 4'd6;
			default: add = 4'd11;
		endcase
		nib = ma[11:8];
		if (ma[12]) begin
			nib = nib + add;
		end
		if (ma[13]) begin
			return {nib[3], 4'hF, ma[9:0]};
		end
		return {nib, ma[7:0], ra[2:0]};
	endfunction

	function automatic logic shadow_ref(
		input bbc_bus_pkg::cpu_addr_t addr,
		input bbc_bus_pkg::acccon_t acc,
		input logic vdu_op,
		input logic sync
	);
		logic in_window;
		in_window = (addr >= 16'h3000) && (addr <= 16'h7FFF);
		return in_window && (acc[2] || (acc[1] && vdu_op && !sync));
	endfunction

	// Original model has no bit 7 in ROM select
	function automatic bbc_bus_pkg::romsel_t romsel_ref(
		input bbc_bus_pkg::cpu_data_t data,
		input logic master
	);
		return master ? data : (data & 8'h7F);
	endfunction

	function automatic bbc_bus_pkg::cpu_data_t readback_ref(
		input bbc_bus_pkg::cpu_addr_t addr,
		input logic master,
		input bbc_bus_pkg::acccon_t acc,
		input bbc_bus_pkg::romsel_t rs
	);
		if (!master) begin
			return 8'h00;
		end
		if ((addr & 16'hFFFC) == ACCCON_ADDR) begin
			return acc;
		end
		if ((addr & 16'hFFFC) == ROMSEL_ADDR) begin
			return rs;
		end
		return 8'h00;
	endfunction

	task automatic check_value(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		n_checks = n_checks + 1;
		assert (got === exp) else begin
			errors = errors + 1;
			$display("** Error at time %0t: %s is %h, expected %h", $time, name, got, exp);
		end
	endtask

	task automatic end_test(input string name, input int errs_before);
		$display("Test %s finished with %0d errors", name, errors - errs_before);
	endtask

	// Hold the bus until a CPU clock enable edge has gone by
	task automatic span_cpu_cycle();
		do begin
			@(negedge clk32m);
		end while (!mem_sync);
		@(negedge clk32m);
	endtask

	task automatic cpu_write(input bbc_bus_pkg::cpu_addr_t addr,
		input bbc_bus_pkg::cpu_data_t data);
		cpu_a = addr;
		cpu_do = data;
		cpu_r_nw = 1'b0;
		cpu_sync = 1'b0;
		span_cpu_cycle();
		cpu_r_nw = 1'b1;
	endtask

	task automatic fetch_opcode(input bbc_bus_pkg::cpu_addr_t addr);
		cpu_a = addr;
		cpu_r_nw = 1'b1;
		cpu_sync = 1'b1;
		span_cpu_cycle();
		cpu_sync = 1'b0;
	endtask

	task automatic read_addr(input bbc_bus_pkg::cpu_addr_t addr, input int cycles);
		cpu_a = addr;
		cpu_r_nw = 1'b1;
		cpu_sync = 1'b0;
		repeat (cycles) @(negedge clk32m);
	endtask

	// Outputs seen here are the values held over the cycle just ending
	always @(posedge clk32m) begin
		if (!reset_n) begin
			ref_phase = 4'd0;
			ref_romsel = 8'h00;
			ref_acccon = 8'h00;
			ref_vdu_op = 1'b0;
			ref_ic32 = 8'h00;
			phi0_run = 0;
		end else begin
			exp_adr = (ref_phase >= 4'd8) ? cpu_a :
				{1'b0, disp_addr_ref(crtc_ma, crtc_ra, ref_ic32[5:4])};
			check_value("phi0_o", 32'(phi0), 32'(ref_phase >= 4'd8));
			check_value("mem_sync_o", 32'(mem_sync), 32'(ref_phase == 4'd15));
			check_value("mem_we_o", 32'(mem_we), 32'(!cpu_r_nw && ref_phase >= 4'd8));
			check_value("mem_adr_o", 32'(mem_adr), 32'(exp_adr));
			check_value("mem_do_o", 32'(mem_do), 32'(cpu_do));
			check_value("romsel_o", 32'(romsel), 32'(ref_romsel));
			check_value("acc_y_o", 32'(acc_y), 32'(ref_acccon[3]));
			check_value("shadow_vid_o", 32'(shadow_vid), 32'(ref_acccon[0]));
			check_value("shadow_ram_o", 32'(shadow_ram),
				32'(shadow_ref(cpu_a, ref_acccon, ref_vdu_op, cpu_sync)));
			if (cpu_r_nw) begin
				check_value("cpu_di_o", 32'(cpu_di),
					32'(readback_ref(cpu_a, model, ref_acccon, ref_romsel)));
			end
			check_value("sound_enable_n_o", 32'(sound_enable_n), 32'(ref_ic32[0]));
			check_value("keyb_enable_n_o", 32'(keyb_enable_n), 32'(ref_ic32[3]));
			check_value("caps_lock_led_n_o", 32'(caps_lock_led_n), 32'(ref_ic32[6]));
			check_value("shift_lock_led_n_o", 32'(shift_lock_led_n), 32'(ref_ic32[7]));

			// Each CPU slot lasts half the memory cycle
			if (phi0) begin
				phi0_run = phi0_run + 1;
			end else if (phi0_run != 0) begin
				check_value("phi0 high run", 32'(phi0_run), 32'd8);
				phi0_run = 0;
			end

			if (ref_phase == 4'd15) begin
				if (!cpu_r_nw && (cpu_a & 16'hFFFC) == ROMSEL_ADDR) begin
					ref_romsel = romsel_ref(cpu_do, model);
				end
				if (!cpu_r_nw && model && (cpu_a & 16'hFFFC) == ACCCON_ADDR) begin
					ref_acccon = cpu_do;
				end
				if (cpu_sync) begin
					ref_vdu_op = (cpu_a >= 16'hC000) && (cpu_a <= 16'hDFFF);
				end
			end
			ref_ic32[sys_pb[2:0]] = sys_pb[3];
			ref_phase = ref_phase + 4'd1;
		end
	end

	always @(posedge clk32m) begin
		cycle_count = cycle_count + 1;
		if (cycle_count >= MAX_CYCLES) begin
			$display("Timeout: tests still running after %0d cycles", cycle_count);
			$display("Testbench failed");
			$finish;
		end
	end

	initial begin
		model = 1'b0;
		cpu_r_nw = 1'b1;
		cpu_sync = 1'b0;
		cpu_a = 16'h0000;
		cpu_do = 8'h00;
		crtc_ma = 14'h0000;
		crtc_ra = 5'h00;
		sys_pb = 8'h00;
		wait (reset_n === 1'b1);
		@(negedge clk32m);

		test_start = errors;
		repeat (64) @(negedge clk32m);
		end_test("clock slots", test_start);

		test_start = errors;
		for (int m = 0; m < 2; m++) begin
			model = m[0];
			for (int i = 0; i < 8; i++) begin
				rnd = $random(seed);
				cpu_write(ROMSEL_ADDR | {14'd0, rnd[9:8]}, rnd[7:0]);
				read_addr(ROMSEL_ADDR, 2);
			end
		end
		end_test("ROM select", test_start);

		test_start = errors;
		model = 1'b1;
		for (int i = 0; i < 8; i++) begin
			rnd = $random(seed);
			cpu_write(ACCCON_ADDR | {14'd0, rnd[9:8]}, rnd[7:0]);
			read_addr(ACCCON_ADDR, 2);
		end
		for (int i = 0; i < 16; i++) begin
			rnd = $random(seed);
			// X and E walk through all four combinations
			cpu_write(ACCCON_ADDR, {rnd[7:3], i[2], i[1], rnd[0]});
			// VDU region fetch on odd passes
			fetch_opcode({(i[0] ? 3'b110 : 3'b111), rnd[20:8]});
			repeat (8) begin
				rnd = $random(seed);
				cpu_a = {1'b0, rnd[14:0]};
				cpu_sync = rnd[16];
				@(negedge clk32m);
			end
			cpu_sync = 1'b0;
		end
		model = 1'b0;
		for (int i = 0; i < 4; i++) begin
			rnd = $random(seed);
			cpu_write(ACCCON_ADDR, rnd[7:0]);
			read_addr(ACCCON_ADDR, 2);
		end
		end_test("access control and shadow RAM", test_start);

		test_start = errors;
		for (int i = 0; i < 64; i++) begin
			rnd = $random(seed);
			sys_pb = rnd[7:0];
			@(negedge clk32m);
		end
		end_test("IC32 latch", test_start);

		test_start = errors;
		for (int offs = 0; offs < 4; offs++) begin
			// IC32 bits 4 and 5 pick the wrap offset
			sys_pb = {4'd0, offs[0], 3'd4};
			@(negedge clk32m);
			sys_pb = {4'd0, offs[1], 3'd5};
			@(negedge clk32m);
			for (int i = 0; i < 32; i++) begin
				rnd = $random(seed);
				crtc_ma = rnd[13:0];
				crtc_ra = rnd[18:14];
				cpu_r_nw = rnd[19];
				cpu_a = {rnd[31:20], rnd[3:0]};
				@(negedge clk32m);
			end
		end
		cpu_r_nw = 1'b1;
		end_test("display address and write gating", test_start);

		$display("Checks: %0d, errors: %0d", n_checks, errors);
		if (errors == 0) begin
			$display("Testbench passed");
		end else begin
			$display("Testbench failed");
		end
		$finish;
	end

endmodule

/* bbc_glue.f */
+incdir+rtl
rtl/bbc_bus_pkg.sv
rtl/bbc_video_pkg.sv
rtl/bbc_clocks.sv
rtl/bbc_sys_regs.sv
rtl/bbc_ic32_latch.sv
rtl/bbc_display_addr.sv
rtl/bbc_glue.sv
tests/tb_clock_gen.sv
tests/tb_bbc_glue.sv

/* Makefile */
TOOL     = verilator
FLAGS    = --binary --timing --assert
TOP      = tb_bbc_glue
RTL_TOP  = bbc_glue
FILELIST = bbc_glue.f
OBJ_DIR  = obj_dir
PASS_MSG = Testbench passed

.PHONY: all build run lint clean

all: run

build:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

# Pass only if the simulation printed the pass line
run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(TOOL) --lint-only --timing --top-module $(RTL_TOP) -f $(FILELIST)
	$(TOOL) --lint-only --timing --assert --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)
